// File: fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// byte address width of the core
`define FETCH_ADDR_W 32

// one cache line as the refill port delivers it
`define ICACHE_LINE_BITS 256

// 32-bit words per line
`define ICACHE_WORDS_PER_LINE 8

// line count, a power of two (32, 64 or 128)
`define ICACHE_LINES 64

// pc loaded by reset
`define FETCH_BOOT_PC 32'hFFFF_E000

// fetch freezes once the pc reaches this address
`define FETCH_HALT_PC 32'h0000_8000

`endif

// File: fetch_core_pkg.sv
`include "fetch_defs.svh"

package fetch_core_pkg;

    // byte address seen by the core
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // one instruction word
    typedef logic [31:0] insn_t;

    // full line from the refill port
    typedef logic [`ICACHE_LINE_BITS-1:0] line_t;

endpackage

// File: icache_pkg.sv
`include "fetch_defs.svh"

package icache_pkg;

    // address split, derived from the line geometry
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_BITS / 8);
    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int TAG_W    = `FETCH_ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORD_W   = $clog2(`ICACHE_WORDS_PER_LINE);

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_W-1:0]  word_off_t;

    // refill and invalidate sequencing
    typedef enum logic [2:0] {
        rs_idle,
        rs_request,
        rs_wait,
        rs_fill,
        rs_invalidate
    } refill_state_t;

endpackage

// File: icache_fetch_if.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

interface icache_fetch_if;

    // lookup request from the pc stage
    logic                  lookup_en;
    fetch_core_pkg::addr_t lookup_addr;
    logic                  hold;

    // lookup result from the cache
    fetch_core_pkg::insn_t insn;
    logic                  hit;
    logic                  busy;

    modport fetch_side (
        output lookup_en,
        output lookup_addr,
        output hold,
        input  insn,
        input  hit,
        input  busy
    );

    modport cache_side (
        input  lookup_en,
        input  lookup_addr,
        input  hold,
        output insn,
        output hit,
        output busy
    );

endinterface

// File: l1icache.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1icache (
    input  logic                  sys_clk,
    input  logic                  rst_n,

    icache_fetch_if.cache_side    lookup,

    input  logic                  sync,

    // refill port
    output logic                  mem_read,
    output fetch_core_pkg::addr_t mem_addr,
    input  logic                  mem_done,
    input  fetch_core_pkg::line_t mem_read_data
);

    localparam int OFFSET_W = icache_pkg::OFFSET_W;
    localparam int INDEX_W  = icache_pkg::INDEX_W;
    localparam int TAG_W    = icache_pkg::TAG_W;

    // line storage
    fetch_core_pkg::line_t line_mem [`ICACHE_LINES];
    icache_pkg::tag_t      tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid;

    icache_pkg::refill_state_t state;
    icache_pkg::refill_state_t state_nxt;

    // lookup address fields
    icache_pkg::tag_t      lk_tag;
    icache_pkg::index_t    lk_index;
    icache_pkg::word_off_t lk_word;
    fetch_core_pkg::line_t lk_line;
    fetch_core_pkg::insn_t hit_word;
    logic                  tag_match;
    logic                  miss;

    // line being refilled
    icache_pkg::tag_t      fill_tag;
    icache_pkg::index_t    fill_index;
    fetch_core_pkg::line_t fill_line;
    logic                  sync_pending;

    assign lk_word  = lookup.lookup_addr[OFFSET_W-1:2];
    assign lk_index = lookup.lookup_addr[OFFSET_W +: INDEX_W];
    assign lk_tag   = lookup.lookup_addr[OFFSET_W + INDEX_W +: TAG_W];

    assign lk_line  = line_mem[lk_index];
    assign hit_word = lk_line[{lk_word, 5'b0} +: 32];

    assign tag_match = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
    assign miss      = lookup.lookup_en && !tag_match;

    // hits are only served while no refill or invalidate is running
    assign lookup.hit  = lookup.lookup_en && tag_match && (state == icache_pkg::rs_idle);
    assign lookup.busy = (state != icache_pkg::rs_idle) || miss;

    assign mem_read = (state == icache_pkg::rs_request) || (state == icache_pkg::rs_wait);
    assign mem_addr = {fill_tag, fill_index, {OFFSET_W{1'b0}}};

    always_comb begin
        state_nxt = state;
        unique case (state)
            icache_pkg::rs_idle: begin
                // a sync waiting behind a refill goes first
                if (sync || sync_pending) begin
                    state_nxt = icache_pkg::rs_invalidate;
                end else if (miss && !lookup.hold) begin
                    state_nxt = icache_pkg::rs_request;
                end
            end
            icache_pkg::rs_request,
            icache_pkg::rs_wait: begin
                if (mem_done) begin
                    state_nxt = icache_pkg::rs_fill;
                end else begin
                    state_nxt = icache_pkg::rs_wait;
                end
            end
            icache_pkg::rs_fill: begin
                state_nxt = icache_pkg::rs_idle;
            end
            icache_pkg::rs_invalidate: begin
                state_nxt = icache_pkg::rs_idle;
            end
            default: begin
                state_nxt = icache_pkg::rs_idle;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= icache_pkg::rs_idle;
            valid        <= '0;
            sync_pending <= 1'b0;
            fill_tag     <= '0;
            fill_index   <= '0;
        end else begin
            state <= state_nxt;

            if (state_nxt == icache_pkg::rs_invalidate) begin
                sync_pending <= 1'b0;
            end else if (sync) begin
                sync_pending <= 1'b1;
            end

            // latch the missing line address for the whole refill
            if (state == icache_pkg::rs_idle && state_nxt == icache_pkg::rs_request) begin
                fill_tag   <= lk_tag;
                fill_index <= lk_index;
            end

            if (state == icache_pkg::rs_fill) begin
                valid[fill_index] <= 1'b1;
            end else if (state == icache_pkg::rs_invalidate) begin
                valid <= '0;
            end
        end
    end

    // data and tag arrays
    always_ff @(posedge sys_clk) begin
        if (mem_read && mem_done) begin
            fill_line <= mem_read_data;
        end
        if (state == icache_pkg::rs_fill) begin
            line_mem[fill_index] <= fill_line;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

    // output word, held while the pc stage is stalled
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup.insn <= '0;
        end else if (lookup.hit && !lookup.hold) begin
            lookup.insn <= hit_word;
        end
    end

endmodule

// File: ifetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ifetch (
    input  logic                  sys_clk,
    input  logic                  rst_n,

    // from execute
    input  logic                  do_jump,
    input  fetch_core_pkg::addr_t jump_addr,

    input  logic                  stall,
    input  logic                  sync,
    output logic                  global_stall,

    output fetch_core_pkg::insn_t ins_out,
    output fetch_core_pkg::addr_t pc_out,
    output fetch_core_pkg::addr_t next_pc_out,

    // refill port, straight to the cache
    output logic                  mem_read,
    output fetch_core_pkg::addr_t mem_addr,
    input  logic                  mem_done,
    input  fetch_core_pkg::line_t mem_read_data
);

    icache_fetch_if il1_if ();

    fetch_core_pkg::addr_t pc;
    fetch_core_pkg::addr_t pc_plus4;
    logic                  working;
    logic                  busy_d;
    logic                  at_halt;
    logic                  advance;

    l1icache il1 (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .lookup        (il1_if.cache_side),
        .sync          (sync),
        .mem_read      (mem_read),
        .mem_addr      (mem_addr),
        .mem_done      (mem_done),
        .mem_read_data (mem_read_data)
    );

    // lookups start one cycle after reset
    assign il1_if.lookup_en   = working;
    assign il1_if.lookup_addr = pc;
    assign il1_if.hold        = stall;

    assign pc_plus4 = pc + 32'd4;
    assign at_halt  = (pc == `FETCH_HALT_PC);

    // pc moves only on a hit in an unstalled cycle
    assign advance = il1_if.hit && !stall && !at_halt;

    assign global_stall = stall || il1_if.busy;

    // bubble for the cycle after any cache activity
    assign ins_out = busy_d ? '0 : il1_if.insn;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `FETCH_BOOT_PC;
        end else if (advance) begin
            if (do_jump) begin
                pc <= jump_addr;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out      <= '0;
            next_pc_out <= '0;
            working     <= 1'b0;
            busy_d      <= 1'b0;
        end else begin
            working <= 1'b1;
            busy_d  <= il1_if.busy;
            // same enable as the cache output word
            if (il1_if.hit && !stall) begin
                pc_out      <= pc;
                next_pc_out <= pc_plus4;
            end
        end
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                  sys_clk,
    input  logic                  rst_n,

    input  logic                  do_jump,
    input  fetch_core_pkg::addr_t jump_addr,
    input  logic                  stall,
    input  logic                  sync,

    output logic                  global_stall,
    output fetch_core_pkg::insn_t ins_out,
    output fetch_core_pkg::addr_t pc_out,
    output fetch_core_pkg::addr_t next_pc_out,

    // external memory refill port
    output logic                  mem_read,
    output fetch_core_pkg::addr_t mem_addr,
    input  logic                  mem_done,
    input  fetch_core_pkg::line_t mem_read_data
);

    ifetch u_ifetch (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .do_jump       (do_jump),
        .jump_addr     (jump_addr),
        .stall         (stall),
        .sync          (sync),
        .global_stall  (global_stall),
        .ins_out       (ins_out),
        .pc_out        (pc_out),
        .next_pc_out   (next_pc_out),
        .mem_read      (mem_read),
        .mem_addr      (mem_addr),
        .mem_done      (mem_done),
        .mem_read_data (mem_read_data)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic sys_clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    // reset low for the first 10 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge sys_clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// File: fetch_unit_checker.sv
`timescale 1ns/1ps

module fetch_unit_checker (
    input logic                  sys_clk,
    input logic                  rst_n,
    input logic                  stall,
    input logic                  global_stall,
    input fetch_core_pkg::insn_t ins_out,
    input fetch_core_pkg::addr_t pc_out,
    input logic                  mem_read,
    input fetch_core_pkg::addr_t mem_addr,
    input logic                  mem_done
);

    int assert_fails;

    initial begin
        assert_fails = 0;
    end

    // refill request holds steady until the memory answers
    a_read_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (mem_read && !mem_done) |=> (mem_read && $stable(mem_addr)))
    else begin
        $error("mem_read or mem_addr changed before mem_done");
        assert_fails++;
    end

    a_line_aligned: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mem_read |-> (mem_addr[4:0] == 5'd0))
    else begin
        $error("mem_addr is not line aligned");
        assert_fails++;
    end

    a_read_drop: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (mem_read && mem_done) |=> !mem_read)
    else begin
        $error("mem_read still high after mem_done");
        assert_fails++;
    end

    // cache activity puts a bubble on the output
    a_bubble: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (global_stall && !stall) |=> (ins_out == '0))
    else begin
        $error("ins_out not zero after a cache stall cycle");
        assert_fails++;
    end

    a_pc_frozen: assert property (@(posedge sys_clk) disable iff (!rst_n)
        global_stall |=> $stable(pc_out))
    else begin
        $error("pc_out moved during a stall");
        assert_fails++;
    end

    a_stall_passes: assert property (@(posedge sys_clk) disable iff (!rst_n)
        stall |-> global_stall)
    else begin
        $error("global_stall low while stall is high");
        assert_fails++;
    end

endmodule

// File: tb_fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_unit;

    logic                  sys_clk;
    logic                  rst_n;
    logic                  do_jump;
    fetch_core_pkg::addr_t jump_addr;
    logic                  stall;
    logic                  sync;
    logic                  global_stall;
    fetch_core_pkg::insn_t ins_out;
    fetch_core_pkg::addr_t pc_out;
    fetch_core_pkg::addr_t next_pc_out;
    logic                  mem_read;
    fetch_core_pkg::addr_t mem_addr;
    logic                  mem_done;
    fetch_core_pkg::line_t mem_read_data;

    integer                seed;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    int                    refills;
    int                    bubbles;
    int                    mem_wait;
    bit                    mem_serving;
    fetch_core_pkg::addr_t seen_pc;

    tb_clock_gen u_clk (
        .sys_clk (sys_clk),
        .rst_n   (rst_n)
    );

    fetch_unit DUT (.*);

    bind fetch_unit fetch_unit_checker u_checker (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .global_stall (global_stall),
        .ins_out      (ins_out),
        .pc_out       (pc_out),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_done     (mem_done)
    );

    // word at byte address a is a ^ A5A5A5A5
    function automatic fetch_core_pkg::line_t build_line(input fetch_core_pkg::addr_t base);
        fetch_core_pkg::line_t l;
        for (int i = 0; i < `ICACHE_WORDS_PER_LINE; i++) begin
            l[i*32 +: 32] = (base + 32'(4 * i)) ^ 32'hA5A5_A5A5;
        end
        return l;
    endfunction

    // memory model, answers after 1 to 6 cycles
    always @(posedge sys_clk) begin
        #2;
        mem_done = 1'b0;
        if (mem_read && !mem_serving) begin
            mem_serving = 1'b1;
            mem_wait = 1 + ($unsigned($random(seed)) % 6);
            refills++;
        end
        if (mem_serving) begin
            if (mem_wait == 1) begin
                mem_done = 1'b1;
                mem_read_data = build_line(mem_addr);
                mem_serving = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    end

    task automatic expect_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAIL at %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    // wait for the next new instruction and check it against the memory rule
    task automatic wait_insn(output fetch_core_pkg::addr_t p);
        int  cycles;
        bit  got;
        logic gs_prev;
        logic st_prev;
        cycles = 0;
        got = 1'b0;
        gs_prev = global_stall;
        st_prev = stall;
        p = pc_out;
        while (!got && cycles < 200) begin
            @(posedge sys_clk);
            #2;
            cycles++;
            if (pc_out != seen_pc) begin
                got = 1'b1;
                seen_pc = pc_out;
                p = pc_out;
                expect_true(ins_out == (pc_out ^ 32'hA5A5_A5A5),
                    $sformatf("ins_out %h wrong for pc %h", ins_out, pc_out));
                expect_true(next_pc_out == pc_out + 32'd4,
                    $sformatf("next_pc_out %h for pc %h", next_pc_out, pc_out));
            end else if (gs_prev && !st_prev) begin
                bubbles++;
                expect_true(ins_out == '0, $sformatf("no bubble, ins_out %h", ins_out));
            end
            gs_prev = global_stall;
            st_prev = stall;
        end
        if (!got) begin
            $display("timed out at %0t ns waiting for the next instruction", $time);
            errors++;
        end
    endtask

    task automatic jump_to(input fetch_core_pkg::addr_t target);
        int cycles;
        cycles = 0;
        while (global_stall && cycles < 200) begin
            @(posedge sys_clk);
            #2;
            cycles++;
        end
        if (global_stall) begin
            $display("timed out at %0t ns waiting for the stage to be free", $time);
            errors++;
        end
        do_jump = 1'b1;
        jump_addr = target;
        @(posedge sys_clk);
        #2;
        do_jump = 1'b0;
        seen_pc = pc_out;
    endtask

    task automatic fetch_run(input int n, input fetch_core_pkg::addr_t first);
        fetch_core_pkg::addr_t p;
        for (int i = 0; i < n; i++) begin
            wait_insn(p);
            expect_true(p == first + 32'(4 * i), $sformatf("pc_out %h in sequence", p));
        end
    endtask

    initial begin
        fetch_core_pkg::addr_t p;
        int e0;
        int r0;
        int cycles;
        seed = 58;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        refills = 0;
        bubbles = 0;
        mem_wait = 0;
        mem_serving = 1'b0;
        seen_pc = '0;
        do_jump = 1'b0;
        jump_addr = '0;
        stall = 1'b0;
        sync = 1'b0;
        mem_done = 1'b0;
        mem_read_data = '0;

        e0 = errors;
        @(posedge sys_clk);
        #2;
        expect_true(!mem_read && !global_stall && ins_out == '0 && pc_out == '0,
            "outputs active during reset");
        cycles = 0;
        while (!rst_n && cycles < 50) begin
            @(posedge sys_clk);
            #2;
            cycles++;
        end
        if (!rst_n) begin
            $display("timed out at %0t ns waiting for reset release", $time);
            errors++;
        end
        wait_insn(p);
        expect_true(p == `FETCH_BOOT_PC, $sformatf("first pc_out %h", p));
        report_test("reset and boot", e0);

        // three line crossings
        e0 = errors;
        r0 = refills;
        fetch_run(24, `FETCH_BOOT_PC + 32'd4);
        expect_true(refills - r0 >= 3, "too few refills across lines");
        report_test("sequential fetch", e0);

        e0 = errors;
        bubbles = 0;
        fetch_run(16, `FETCH_BOOT_PC + 32'd100);
        expect_true(bubbles > 0, "no bubble seen on a line crossing");
        report_test("miss bubble", e0);

        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            stall = 1'($random(seed));
            @(posedge sys_clk);
            #2;
            if (pc_out != seen_pc) begin
                expect_true(!stall, "pc_out moved while stalled");
                expect_true(pc_out == seen_pc + 32'd4, $sformatf("pc_out %h after stall", pc_out));
                expect_true(ins_out == (pc_out ^ 32'hA5A5_A5A5), "ins_out wrong after stall");
                seen_pc = pc_out;
            end else begin
                // held output is either the bubble or the word of the held pc
                expect_true(ins_out == '0 || ins_out == (pc_out ^ 32'hA5A5_A5A5),
                    $sformatf("ins_out %h while pc_out %h holds", ins_out, pc_out));
            end
        end
        stall = 1'b0;
        p = seen_pc;
        fetch_run(4, p + 32'd4);
        report_test("external stall", e0);

        e0 = errors;
        jump_to(`FETCH_BOOT_PC + 32'd8);
        r0 = refills;
        fetch_run(4, `FETCH_BOOT_PC + 32'd8);
        expect_true(refills == r0, "refill on a jump into a cached line");
        jump_to(32'h0000_1400);
        r0 = refills;
        fetch_run(4, 32'h0000_1400);
        expect_true(refills == r0 + 1, "expected one refill on a jump to a new line");
        report_test("jump", e0);

        e0 = errors;
        sync = 1'b1;
        @(posedge sys_clk);
        #2;
        sync = 1'b0;
        seen_pc = pc_out;
        fetch_run(2, seen_pc + 32'd4);
        r0 = refills;
        jump_to(`FETCH_BOOT_PC + 32'd8);
        fetch_run(1, `FETCH_BOOT_PC + 32'd8);
        expect_true(refills > r0, "no refill after sync");
        jump_to(`FETCH_HALT_PC - 32'd8);
        fetch_run(3, `FETCH_HALT_PC - 32'd8);
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            #2;
            expect_true(pc_out == `FETCH_HALT_PC, $sformatf("pc_out %h at halt", pc_out));
        end
        report_test("sync and halt", e0);

        errors = errors + DUT.u_checker.assert_fails;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: fetch_unit.f
+incdir+.
fetch_core_pkg.sv
icache_pkg.sv
icache_fetch_if.sv
l1icache.sv
ifetch.sv
fetch_unit.sv
tb_clock_gen.sv
fetch_unit_checker.sv
tb_fetch_unit.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal -f fetch_unit.f \
		--top-module tb_fetch_unit -Mdir obj_dir
	./obj_dir/Vtb_fetch_unit 2>&1 | tee sim.log
	@if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
